// File: rtl/platformer_pkg.sv
// Platformer shared definitions
`default_nettype none

package platformer_pkg;

	// -------------------------------------------------------------------------
	// map and player geometry
	// -------------------------------------------------------------------------
	localparam int TILE_SHIFT = 5;
	localparam int MAP_ROWS = 15;
	localparam int MAP_COLS = 60;
	localparam int FLOOR_ROW = 11;

	// two stacked block rows
	localparam int BLOCK_ROW_LO = 10;
	localparam int BLOCK_LO_C0 = 14;
	localparam int BLOCK_LO_C1 = 17;
	localparam int BLOCK_ROW_HI = 9;
	localparam int BLOCK_HI_C0 = 15;
	localparam int BLOCK_HI_C1 = 16;

	localparam int PLAYER_W = 26;
	localparam int PLAYER_H = 32;
	localparam int SPAWN_X = 228;
	localparam int SPAWN_Y = 33;
	localparam int SCREEN_MIN_X = 190;
	localparam int SCREEN_MAX_X = 384;
	localparam int FALL_MAX = 6;
	localparam int WALK_MAX = 4;

	// coins
	localparam int COIN_COUNT = 3;
	localparam int COIN_ROW = 10;
	localparam int COIN_COL0 = 8;
	localparam int COIN_COL1 = 10;
	localparam int COIN_COL2 = 12;
	localparam logic [COIN_COUNT-1:0][6:0] COIN_COLS = {7'(COIN_COL2), 7'(COIN_COL1),
		7'(COIN_COL0)};

	// -------------------------------------------------------------------------
	// types
	// -------------------------------------------------------------------------
	typedef logic [9:0] coord_t;
	typedef logic [11:0] world_t;

	typedef enum logic [7:0] {KEY_NONE = 8'h00, KEY_LEFT = 8'h04, KEY_RIGHT = 8'h07} key_code_t;
	typedef enum logic [1:0] {TILE_SKY, TILE_FLOOR, TILE_BLOCK, TILE_COIN} tile_kind_t;
	typedef enum logic [1:0] {IDLE, FALL, WALK, DONE} phys_state_t;

	typedef struct packed {
		world_t x;
		coord_t y;
	} point_t;

	typedef struct packed {
		point_t a;
		point_t b;
	} probe_req_t;

	// bottom-right corner on screen plus scroll
	typedef struct packed {
		coord_t x;
		coord_t y;
		world_t scroll;
	} player_box_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// flat palette
	localparam rgb_t COLOR_SKY = 24'h6185F8;
	localparam rgb_t COLOR_FLOOR = 24'hA55C39;
	localparam rgb_t COLOR_BLOCK = 24'h833D00;
	localparam rgb_t COLOR_COIN = 24'hFFC107;
	localparam rgb_t COLOR_PLAYER = 24'hF83800;
	localparam rgb_t COLOR_BLANK = 24'h000000;

endpackage

`default_nettype wire

// File: rtl/level_map.sv
// Level tile map and coins
`timescale 1ns/1ns
`default_nettype none

module level_map (
	input  wire logic                        Clk,
	input  wire logic                        Reset,
	input  wire platformer_pkg::probe_req_t  probe,
	output logic [1:0]                       probe_solid,
	input  wire platformer_pkg::player_box_t player,
	input  wire logic                        frame_done,
	input  wire platformer_pkg::point_t      render_pt,
	output platformer_pkg::tile_kind_t       render_kind,
	output logic [1:0]                       score
);
	import platformer_pkg::*;

	logic [COIN_COUNT-1:0] coin_present;
	logic [COIN_COUNT-1:0] coin_hit;
	world_t right_wx;
	world_t left_wx;
	coord_t top_y;
	logic [6:0] col_right;
	logic [6:0] col_left;
	logic [4:0] row_bot;
	logic [4:0] row_top;

	function automatic logic [6:0] tile_col(input world_t x);
		return 7'(x >> TILE_SHIFT);
	endfunction

	function automatic logic [4:0] tile_row(input coord_t y);
		return 5'(y >> TILE_SHIFT);
	endfunction

	// -------------------------------------------------------------------------
	// fixed layout
	// -------------------------------------------------------------------------
	function automatic tile_kind_t classify(input point_t pt, input logic [COIN_COUNT-1:0] coins);
		logic [6:0] col;
		logic [4:0] row;
		tile_kind_t kind;
		col = tile_col(pt.x);
		row = tile_row(pt.y);
		kind = TILE_SKY;
		// anything under the map is ground
		if (row >= MAP_ROWS)
			kind = TILE_FLOOR;
		else if (col >= MAP_COLS)
			kind = TILE_SKY;
		else if (row >= FLOOR_ROW)
			kind = TILE_FLOOR;
		else if (row == BLOCK_ROW_LO && col >= BLOCK_LO_C0 && col <= BLOCK_LO_C1)
			kind = TILE_BLOCK;
		else if (row == BLOCK_ROW_HI && col >= BLOCK_HI_C0 && col <= BLOCK_HI_C1)
			kind = TILE_BLOCK;
		else if (row == COIN_ROW) begin
			for (int i = 0; i < COIN_COUNT; i++) begin
				if (coins[i] && col == COIN_COLS[i])
					kind = TILE_COIN;
			end
		end
		return kind;
	endfunction

	function automatic logic is_solid(input tile_kind_t kind);
		return (kind == TILE_FLOOR) || (kind == TILE_BLOCK);
	endfunction

	assign probe_solid[0] = is_solid(classify(probe.a, coin_present));
	assign probe_solid[1] = is_solid(classify(probe.b, coin_present));
	// collected coins fall through to sky
	assign render_kind = classify(render_pt, coin_present);

	// -------------------------------------------------------------------------
	// coin pickup on the four box corners
	// -------------------------------------------------------------------------
	assign right_wx = world_t'(player.x) + player.scroll;
	assign left_wx = right_wx - world_t'(PLAYER_W - 1);
	assign top_y = player.y - coord_t'(PLAYER_H - 1);
	assign col_right = tile_col(right_wx);
	assign col_left = tile_col(left_wx);
	assign row_bot = tile_row(player.y);
	assign row_top = tile_row(top_y);

	always_comb begin
		for (int i = 0; i < COIN_COUNT; i++) begin
			coin_hit[i] = coin_present[i] && (row_bot == COIN_ROW || row_top == COIN_ROW) &&
				(col_right == COIN_COLS[i] || col_left == COIN_COLS[i]);
		end
	end

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset)
			coin_present <= '1;
		else if (frame_done)
			coin_present <= coin_present & ~coin_hit;
	end

	assign score = 2'($countones(~coin_present));

	// a collected coin stays collected
	assert property (@(posedge Clk) disable iff (Reset)
		(coin_present & ~$past(coin_present)) == '0);

endmodule

`default_nettype wire

// File: rtl/player_physics.sv
// Player gravity, walking and scroll
`timescale 1ns/1ns
`default_nettype none

module player_physics (
	input  wire logic                        Clk,
	input  wire logic                        Reset,
	input  wire logic                        frame_tick,
	input  wire platformer_pkg::key_code_t   key,
	output platformer_pkg::probe_req_t       probe,
	input  wire logic [1:0]                  probe_solid,
	output platformer_pkg::player_box_t      player,
	output logic                             frame_done
);
	import platformer_pkg::*;

	phys_state_t state;
	key_code_t key_q;
	logic [2:0] fall_speed;
	logic [2:0] speed_next;
	logic [2:0] step_cnt;
	world_t right_wx;
	world_t left_wx;
	coord_t top_y;
	logic moving_right;
	logic at_left_bound;
	logic blocked;

	// box corners in world space
	assign right_wx = world_t'(player.x) + player.scroll;
	assign left_wx = right_wx - world_t'(PLAYER_W - 1);
	assign top_y = player.y - coord_t'(PLAYER_H - 1);

	assign moving_right = (key_q == KEY_RIGHT);
	assign at_left_bound = (player.x == coord_t'(SCREEN_MIN_X + PLAYER_W - 1));
	assign speed_next = (fall_speed >= 3'(FALL_MAX)) ? 3'(FALL_MAX) : fall_speed + 3'd1;

	// wall ahead, or left screen edge with nothing left to scroll
	assign blocked = (|probe_solid) ||
		(!moving_right && at_left_bound && player.scroll == '0);

	assign frame_done = (state == DONE);

	// -------------------------------------------------------------------------
	// probe points
	// -------------------------------------------------------------------------
	always_comb begin
		// bottom corners, one pixel down
		probe.a.x = right_wx;
		probe.a.y = player.y + 1'b1;
		probe.b.x = left_wx;
		probe.b.y = player.y + 1'b1;
		if (state == WALK) begin
			// leading edge, one pixel ahead
			if (moving_right) begin
				probe.a.x = right_wx + 1'b1;
				probe.b.x = right_wx + 1'b1;
			end else begin
				probe.a.x = left_wx - 1'b1;
				probe.b.x = left_wx - 1'b1;
			end
			probe.a.y = player.y;
			probe.b.y = top_y;
		end
	end

	// -------------------------------------------------------------------------
	// frame update FSM
	// -------------------------------------------------------------------------
	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			state <= IDLE;
			key_q <= KEY_NONE;
			fall_speed <= '0;
			step_cnt <= '0;
			player.x <= coord_t'(SPAWN_X);
			player.y <= coord_t'(SPAWN_Y);
			player.scroll <= '0;
		end else begin
			unique case (state)
				IDLE: begin
					if (frame_tick) begin
						key_q <= (key == KEY_LEFT || key == KEY_RIGHT) ? key : KEY_NONE;
						fall_speed <= speed_next;
						step_cnt <= speed_next;
						state <= FALL;
					end
				end
				FALL: begin
					if (|probe_solid) begin
						// landed early
						fall_speed <= '0;
						step_cnt <= 3'(WALK_MAX);
						state <= (key_q == KEY_NONE) ? DONE : WALK;
					end else begin
						player.y <= player.y + 1'b1;
						if (step_cnt == 3'd1) begin
							step_cnt <= 3'(WALK_MAX);
							state <= (key_q == KEY_NONE) ? DONE : WALK;
						end else begin
							step_cnt <= step_cnt - 3'd1;
						end
					end
				end
				WALK: begin
					step_cnt <= step_cnt - 3'd1;
					if (blocked || step_cnt == 3'd1)
						state <= DONE;
					if (!blocked) begin
						if (moving_right) begin
							if (player.x == coord_t'(SCREEN_MAX_X))
								player.scroll <= player.scroll + 1'b1;
							else
								player.x <= player.x + 1'b1;
						end else begin
							if (at_left_bound)
								player.scroll <= player.scroll - 1'b1;
							else
								player.x <= player.x - 1'b1;
						end
					end
				end
				DONE: state <= IDLE;
			endcase
		end
	end

	assert property (@(posedge Clk) disable iff (Reset)
		(player.scroll == '0) |=> (player.scroll <= world_t'(1)));

	assert property (@(posedge Clk) disable iff (Reset) frame_done |=> !frame_done);

endmodule

`default_nettype wire

// File: rtl/pixel_renderer.sv
// Pixel colour renderer
`timescale 1ns/1ns
`default_nettype none

module pixel_renderer (
	input  wire logic                        Clk,
	input  wire logic                        Reset,
	input  wire logic                        blank,
	input  wire platformer_pkg::coord_t      draw_x,
	input  wire platformer_pkg::coord_t      draw_y,
	input  wire platformer_pkg::player_box_t player,
	output platformer_pkg::point_t           render_pt,
	input  wire platformer_pkg::tile_kind_t  render_kind,
	output platformer_pkg::rgb_t             rgb
);
	import platformer_pkg::*;

	logic in_x;
	logic in_y;
	rgb_t tile_color;

	// box spans corner minus size plus one up to the corner
	assign in_x = (draw_x <= player.x) &&
		({1'b0, draw_x} + 11'(PLAYER_W - 1) >= {1'b0, player.x});
	assign in_y = (draw_y <= player.y) &&
		({1'b0, draw_y} + 11'(PLAYER_H - 1) >= {1'b0, player.y});

	always_comb begin
		render_pt.x = world_t'(draw_x) + player.scroll;
		render_pt.y = draw_y;
	end

	always_comb begin
		case (render_kind)
			TILE_FLOOR: tile_color = COLOR_FLOOR;
			TILE_BLOCK: tile_color = COLOR_BLOCK;
			TILE_COIN:  tile_color = COLOR_COIN;
			default:    tile_color = COLOR_SKY;
		endcase
	end

	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset)
			rgb <= '0;
		else if (!blank)
			rgb <= COLOR_BLANK;
		else if (in_x && in_y)
			rgb <= COLOR_PLAYER;
		else
			rgb <= tile_color;
	end

endmodule

`default_nettype wire

// File: rtl/platformer_top.sv
// Platformer core top level
`timescale 1ns/1ns
`default_nettype none

module platformer_top (
	input  wire logic                        Clk,
	input  wire logic                        Reset,
	input  wire logic                        frame_tick,
	input  wire logic                        blank,
	input  wire platformer_pkg::key_code_t   key,
	input  wire platformer_pkg::coord_t      draw_x,
	input  wire platformer_pkg::coord_t      draw_y,
	output platformer_pkg::player_box_t      player,
	output logic [1:0]                       score,
	output logic                             frame_done,
	output platformer_pkg::rgb_t             rgb
);
	import platformer_pkg::*;

	// physics to map
	probe_req_t probe;
	logic [1:0] probe_solid;

	// renderer to map
	point_t render_pt;
	tile_kind_t render_kind;

	level_map u_map (
		.Clk         (Clk),
		.Reset       (Reset),
		.probe       (probe),
		.probe_solid (probe_solid),
		.player      (player),
		.frame_done  (frame_done),
		.render_pt   (render_pt),
		.render_kind (render_kind),
		.score       (score)
	);

	player_physics u_physics (
		.Clk         (Clk),
		.Reset       (Reset),
		.frame_tick  (frame_tick),
		.key         (key),
		.probe       (probe),
		.probe_solid (probe_solid),
		.player      (player),
		.frame_done  (frame_done)
	);

	pixel_renderer u_renderer (
		.Clk         (Clk),
		.Reset       (Reset),
		.blank       (blank),
		.draw_x      (draw_x),
		.draw_y      (draw_y),
		.player      (player),
		.render_pt   (render_pt),
		.render_kind (render_kind),
		.rgb         (rgb)
	);

endmodule

`default_nettype wire

// File: verif/platformer_tests.svh
// Platformer directed tests

// box for a right edge at world x, walking right from spawn
function automatic player_box_t expected_box(input int right, input int y);
	player_box_t box;
	box.x = coord_t'((right > SCREEN_MAX_X) ? SCREEN_MAX_X : right);
	box.y = coord_t'(y);
	box.scroll = world_t'(right) - world_t'(box.x);
	return box;
endfunction

// coins whose column the right edge has reached
function automatic int coins_reached(input int right);
	int n;
	n = 0;
	if (right >= (COIN_COL0 << TILE_SHIFT))
		n++;
	if (right >= (COIN_COL1 << TILE_SHIFT))
		n++;
	if (right >= (COIN_COL2 << TILE_SHIFT))
		n++;
	return n;
endfunction

// ----------------------------------------------------------------------------
// directed tests
// ----------------------------------------------------------------------------
task automatic test_reset();
	@(negedge Clk);
	compare("reset player", expected_box(SPAWN_X, SPAWN_Y), player);
	compare("reset score", 0, score);
	compare("reset rgb", 0, rgb);
	compare("reset frame_done", 0, frame_done);
endtask

task automatic test_landing();
	repeat (80) run_frame(KEY_NONE);
	compare("landing", expected_box(SPAWN_X, GROUND_Y), player);
	repeat (5) run_frame(KEY_NONE);
	compare("landing rest", expected_box(SPAWN_X, GROUND_Y), player);
	compare("landing score", 0, score);
endtask

task automatic test_coins();
	while (right_edge < (COIN_COL2 << TILE_SHIFT)) begin
		run_frame(KEY_RIGHT);
		right_edge = right_edge + WALK_MAX;
		compare("coins player", expected_box(right_edge, GROUND_Y), player);
		compare("coins score", coins_reached(right_edge), score);
	end
	compare("coins final", COIN_COUNT, score);
endtask

task automatic test_wall();
	repeat (80) begin
		run_frame(KEY_RIGHT);
		right_edge = right_edge + WALK_MAX;
		if (right_edge > WALL_RIGHT)
			right_edge = WALL_RIGHT;
		compare("wall player", expected_box(right_edge, GROUND_Y), player);
	end
	compare("wall x", SCREEN_MAX_X, player.x);
	compare("wall scroll", WALL_RIGHT - SCREEN_MAX_X, player.scroll);
endtask

// rgb is checked one cycle after the draw inputs
task automatic render_pixel(input string name, input logic vis, input int x, input int y,
	input rgb_t want);
	@(posedge Clk);
	blank <= vis;
	draw_x <= coord_t'(x);
	draw_y <= coord_t'(y);
	@(posedge Clk);
	@(negedge Clk);
	compare(name, want, rgb);
endtask

task automatic test_render();
	int scroll;
	scroll = WALL_RIGHT - SCREEN_MAX_X;
	render_pixel("render player", 1'b1, SCREEN_MAX_X - 4, GROUND_Y - 11, COLOR_PLAYER);
	render_pixel("render floor", 1'b1, 100, 400, COLOR_FLOOR);
	render_pixel("render sky", 1'b1, 100, 10, COLOR_SKY);
	render_pixel("render blank", 1'b0, SCREEN_MAX_X - 4, GROUND_Y - 11, COLOR_BLANK);
	// first coin was collected, its tile shows sky
	render_pixel("render coin", 1'b1, (COIN_COL0 << TILE_SHIFT) + 10 - scroll,
		(COIN_ROW << TILE_SHIFT) + 10, COLOR_SKY);
	render_pixel("render block", 1'b1, (14 << TILE_SHIFT) + 12 - scroll,
		(10 << TILE_SHIFT) + 10, COLOR_BLOCK);
endtask

// File: verif/platformer_tb.sv
// Platformer core testbench
`timescale 1ns/1ns
`default_nettype none

module platformer_tb;
	import platformer_pkg::*;

	// landing height is the top of the first floor row, minus one
	localparam int GROUND_Y = (11 << TILE_SHIFT) - 1;
	// left edge of the first block column, minus one
	localparam int WALL_RIGHT = (14 << TILE_SHIFT) - 1;
	// about 204 frames at up to 12 cycles each, plus reset and render
	localparam int CYCLE_LIMIT = 204 * 12 + 200;

	logic Clk;
	logic Reset;
	logic frame_tick;
	logic blank;
	key_code_t key;
	coord_t draw_x;
	coord_t draw_y;
	player_box_t player;
	logic [1:0] score;
	logic frame_done;
	rgb_t rgb;

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	// modelled world x of the box's right edge
	int right_edge;

	platformer_top dut (.*);

	initial Clk = 1'b0;
	always #2 Clk = ~Clk;

	// ------------------------------------------------------------------------
	// run limit
	// ------------------------------------------------------------------------
	always @(posedge Clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("** Error [%s] expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// one frame update, key held from the tick
	task automatic run_frame(input key_code_t k);
		@(posedge Clk);
		frame_tick <= 1'b1;
		key <= k;
		@(posedge Clk);
		frame_tick <= 1'b0;
		@(negedge Clk);
		while (!frame_done)
			@(negedge Clk);
		// coin bits update on the edge after frame_done
		@(negedge Clk);
		// frame end is a single-cycle pulse
		compare("frame end pulse", 0, frame_done);
	endtask

	`include "platformer_tests.svh"

	initial begin
		Reset = 1'b1;
		frame_tick = 1'b0;
		blank = 1'b0;
		key = KEY_NONE;
		draw_x = '0;
		draw_y = '0;
		right_edge = SPAWN_X;
		repeat (8) @(posedge Clk);
		Reset <= 1'b0;
		test_reset();
		test_landing();
		test_coins();
		test_wall();
		test_render();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: platformer_top.f
+incdir+verif
rtl/platformer_pkg.sv
rtl/level_map.sv
rtl/player_physics.sv
rtl/pixel_renderer.sv
rtl/platformer_top.sv
verif/platformer_tb.sv
